/* Makefile */
.PHONY: run clean

run: obj_dir/Vtb_radio_core
	@out="$$(./obj_dir/Vtb_radio_core +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

obj_dir/Vtb_radio_core: flist.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_radio_core \
		-f flist.f -o Vtb_radio_core

clean:
	rm -rf obj_dir

/* flist.f */
radio_signal_pkg.sv
radio_regs_pkg.sv
wb_settings_slave.sv
radio_timekeeper.sv
radio_frontend_ctrl.sv
gpio_atr_bank.sv
radio_readback_mux.sv
radio_core_top.sv
radio_core_assertions.sv
tb_radio_core.sv

/* gpio_atr_bank.sv */
// One ATR GPIO bank: drives pins from the idle, receive, transmit or full-duplex word
module gpio_atr_bank #(
   parameter int GPIO_WIDTH = radio_signal_pkg::GPIO_DEFAULT_W,
   parameter int ATR_BASE   = radio_regs_pkg::SR_ATR_BASE
) (
   input  logic                          i_radio_clk,
   input  logic                          i_radio_rst,
   input  logic                          i_set_stb,
   input  radio_signal_pkg::set_addr_t   i_set_addr,
   input  radio_signal_pkg::wb_data_t    i_set_data,
   input  logic                          i_run_rx,
   input  logic                          i_run_tx,
   input  logic [GPIO_WIDTH-1:0]         i_gpio_in,
   output logic [GPIO_WIDTH-1:0]         o_gpio_out,
   output logic [GPIO_WIDTH-1:0]         o_gpio_ddr,
   output logic [GPIO_WIDTH-1:0]         o_gpio_rb
);
   import radio_signal_pkg::*;
   import radio_regs_pkg::*;

   // This bank's five addresses
   localparam set_addr_t ADDR_IDLE = set_addr_t'(ATR_BASE + ATR_IDLE);
   localparam set_addr_t ADDR_RX   = set_addr_t'(ATR_BASE + ATR_RX);
   localparam set_addr_t ADDR_TX   = set_addr_t'(ATR_BASE + ATR_TX);
   localparam set_addr_t ADDR_FDX  = set_addr_t'(ATR_BASE + ATR_FDX);
   localparam set_addr_t ADDR_DDR  = set_addr_t'(ATR_BASE + ATR_DDR);

   logic [GPIO_WIDTH-1:0] atr_idle;
   logic [GPIO_WIDTH-1:0] atr_rx;
   logic [GPIO_WIDTH-1:0] atr_tx;
   logic [GPIO_WIDTH-1:0] atr_fdx;
   logic [GPIO_WIDTH-1:0] atr_ddr;
   logic [GPIO_WIDTH-1:0] atr_word;

   ////////////////////////////////////////
   // State and direction registers

   // Pins default to outputs so they keep driving through a reset
   always_ff @(posedge i_radio_clk) begin
      if (i_radio_rst) begin
         atr_idle <= '0;
         atr_rx   <= '0;
         atr_tx   <= '0;
         atr_fdx  <= '0;
         atr_ddr  <= '1;
      end else if (i_set_stb) begin
         case (i_set_addr)
            ADDR_IDLE: atr_idle <= i_set_data[GPIO_WIDTH-1:0];
            ADDR_RX:   atr_rx   <= i_set_data[GPIO_WIDTH-1:0];
            ADDR_TX:   atr_tx   <= i_set_data[GPIO_WIDTH-1:0];
            ADDR_FDX:  atr_fdx  <= i_set_data[GPIO_WIDTH-1:0];
            ADDR_DDR:  atr_ddr  <= i_set_data[GPIO_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Output select

   always_comb begin
      case ({i_run_tx, i_run_rx})
         2'b01:   atr_word = atr_rx;
         2'b10:   atr_word = atr_tx;
         2'b11:   atr_word = atr_fdx;
         default: atr_word = atr_idle;
      endcase
   end

   always_ff @(posedge i_radio_clk) begin
      if (i_radio_rst) begin
         o_gpio_out <= '0;
         o_gpio_ddr <= '1;
      end else begin
         o_gpio_out <= atr_word;
         o_gpio_ddr <= atr_ddr;
      end
   end

   // Pin sample for the host
   always_ff @(posedge i_radio_clk) begin
      o_gpio_rb <= i_gpio_in;
   end

endmodule

/* radio_core_assertions.sv */
// Wishbone acknowledge and settings strobe properties, bound into every wb_settings_slave
module radio_core_assertions (
   input logic i_radio_clk,
   input logic i_radio_rst,
   input logic i_wb_cyc,
   input logic i_wb_stb,
   input logic i_wb_we,
   input logic i_wb_ack,
   input logic i_set_stb
);

   int unsigned fail_count = 0;

   ////////////////////////////////////////
   // Handshake

   // Acknowledge is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge i_radio_clk) disable iff (i_radio_rst)
      i_wb_ack |=> !i_wb_ack)
      else begin
         $error("Wishbone acknowledge high for two cycles in a row");
         fail_count++;
      end

   ack_after_request: assert property (@(posedge i_radio_clk) disable iff (i_radio_rst)
      i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
      else begin
         $error("Wishbone acknowledge without a request");
         fail_count++;
      end

   // Settings strobe only with the acknowledge of a write
   stb_with_write_ack: assert property (@(posedge i_radio_clk) disable iff (i_radio_rst)
      i_set_stb |-> (i_wb_ack && $past(i_wb_we)))
      else begin
         $error("Settings strobe outside a write acknowledge");
         fail_count++;
      end

   ack_low_after_reset: assert property (@(posedge i_radio_clk)
      i_radio_rst |=> !i_wb_ack)
      else begin
         $error("Wishbone acknowledge high after reset");
         fail_count++;
      end

endmodule

bind wb_settings_slave radio_core_assertions u_wb_assert (
   .i_radio_clk (i_radio_clk),
   .i_radio_rst (i_radio_rst),
   .i_wb_cyc    (i_wb_cyc),
   .i_wb_stb    (i_wb_stb),
   .i_wb_we     (i_wb_we),
   .i_wb_ack    (o_wb_ack),
   .i_set_stb   (o_set_stb)
);

/* radio_core_top.sv */
// Radio-clock control plane top: Wishbone settings, timekeeper, front end, ATR banks, readback
module radio_core_top #(
   parameter int NUM_ATR_BANKS = 2,
   parameter int GPIO_WIDTH    = radio_signal_pkg::GPIO_DEFAULT_W
) (
   input  logic                                i_radio_clk,
   input  logic                                i_radio_rst,
   // Wishbone classic slave
   input  logic                                i_wb_cyc,
   input  logic                                i_wb_stb,
   input  logic                                i_wb_we,
   input  radio_signal_pkg::set_addr_t         i_wb_adr,
   input  radio_signal_pkg::wb_data_t          i_wb_dat,
   output radio_signal_pkg::wb_data_t          o_wb_dat,
   output logic                                o_wb_ack,
   // Front end
   input  radio_signal_pkg::iq_word_t          i_rx,
   output radio_signal_pkg::iq_word_t          o_tx,
   output radio_signal_pkg::iq_word_t          o_rx_fe,
   input  radio_signal_pkg::iq_word_t          i_tx_sample,
   input  logic                                i_run_tx,
   input  logic                                i_run_rx,
   input  logic                                i_pps,
   // GPIO, bank 0 in the low slice
   input  logic [NUM_ATR_BANKS*GPIO_WIDTH-1:0] i_gpio_in,
   output logic [NUM_ATR_BANKS*GPIO_WIDTH-1:0] o_gpio_out,
   output logic [NUM_ATR_BANKS*GPIO_WIDTH-1:0] o_gpio_ddr
);
   import radio_signal_pkg::*;
   import radio_regs_pkg::*;

   logic                            set_stb;
   set_addr_t                       set_addr;
   wb_data_t                        set_data;
   rb_word_t                        rb_data;
   vita_time_t                      vita_time;
   vita_time_t                      vita_time_pps;
   wb_data_t                        test_word;
   logic [RB_SEL_W-1:0]             rb_sel;
   logic [NUM_ATR_BANKS*GPIO_WIDTH-1:0] gpio_rb;

   wb_settings_slave u_wb_slave (
      .i_radio_clk (i_radio_clk),  .i_radio_rst (i_radio_rst),
      .i_wb_cyc    (i_wb_cyc),     .i_wb_stb    (i_wb_stb),
      .i_wb_we     (i_wb_we),      .i_wb_adr    (i_wb_adr),
      .i_wb_dat    (i_wb_dat),     .o_wb_dat    (o_wb_dat),
      .o_wb_ack    (o_wb_ack),     .o_set_stb   (set_stb),
      .o_set_addr  (set_addr),     .o_set_data  (set_data),
      .i_rb_data   (rb_data)
   );

   radio_timekeeper u_timekeeper (
      .i_radio_clk (i_radio_clk), .i_radio_rst (i_radio_rst),
      .i_set_stb   (set_stb),     .i_set_addr  (set_addr),     .i_set_data (set_data),
      .i_pps       (i_pps),       .o_vita_time (vita_time),    .o_vita_time_pps (vita_time_pps)
   );

   radio_frontend_ctrl u_frontend (
      .i_radio_clk (i_radio_clk), .i_radio_rst (i_radio_rst),
      .i_set_stb   (set_stb),     .i_set_addr  (set_addr),     .i_set_data (set_data),
      .i_rx        (i_rx),        .i_tx_sample (i_tx_sample),  .i_run_tx   (i_run_tx),
      .o_tx        (o_tx),        .o_rx_fe     (o_rx_fe),
      .o_test_word (test_word),   .o_rb_sel    (rb_sel)
   );

   ////////////////////////////////////////
   // ATR banks, one address window each

   for (genvar k = 0; k < NUM_ATR_BANKS; k++) begin : g_atr_bank
      gpio_atr_bank #(
         .GPIO_WIDTH (GPIO_WIDTH),
         .ATR_BASE   (SR_ATR_BASE + k * SR_ATR_STRIDE)
      ) u_atr (
         .i_radio_clk (i_radio_clk), .i_radio_rst (i_radio_rst),
         .i_set_stb   (set_stb),     .i_set_addr  (set_addr),  .i_set_data (set_data),
         .i_run_rx    (i_run_rx),    .i_run_tx    (i_run_tx),
         .i_gpio_in   (i_gpio_in[k*GPIO_WIDTH +: GPIO_WIDTH]),
         .o_gpio_out  (o_gpio_out[k*GPIO_WIDTH +: GPIO_WIDTH]),
         .o_gpio_ddr  (o_gpio_ddr[k*GPIO_WIDTH +: GPIO_WIDTH]),
         .o_gpio_rb   (gpio_rb[k*GPIO_WIDTH +: GPIO_WIDTH])
      );
   end

   radio_readback_mux #(.NUM_ATR_BANKS(NUM_ATR_BANKS), .GPIO_WIDTH(GPIO_WIDTH)) u_rb_mux (
      .i_rb_sel        (rb_sel),        .i_vita_time (vita_time),
      .i_vita_time_pps (vita_time_pps), .i_test_word (test_word),
      .i_tx            (o_tx),          .i_rx        (i_rx),
      .i_gpio_rb       (gpio_rb),       .o_rb_data   (rb_data)
   );

endmodule

/* radio_frontend_ctrl.sv */
// Loopback, test, idle and readback-select settings with the registered transmit and receive words
module radio_frontend_ctrl (
   input  logic                                 i_radio_clk,
   input  logic                                 i_radio_rst,
   input  logic                                 i_set_stb,
   input  radio_signal_pkg::set_addr_t          i_set_addr,
   input  radio_signal_pkg::wb_data_t           i_set_data,
   input  radio_signal_pkg::iq_word_t           i_rx,
   input  radio_signal_pkg::iq_word_t           i_tx_sample,
   input  logic                                 i_run_tx,
   output radio_signal_pkg::iq_word_t           o_tx,
   output radio_signal_pkg::iq_word_t           o_rx_fe,
   output radio_signal_pkg::wb_data_t           o_test_word,
   output logic [radio_regs_pkg::RB_SEL_W-1:0]  o_rb_sel
);
   import radio_signal_pkg::*;
   import radio_regs_pkg::*;

   logic     loopback;
   iq_word_t tx_idle;

   ////////////////////////////////////////
   // Settings registers

   always_ff @(posedge i_radio_clk) begin
      if (i_radio_rst) begin
         loopback    <= 1'b0;
         o_test_word <= '0;
         tx_idle     <= '0;
         o_rb_sel    <= RB_TEST;
      end else if (i_set_stb) begin
         case (i_set_addr)
            SR_LOOPBACK:   loopback    <= i_set_data[0];
            SR_TEST:       o_test_word <= i_set_data;
            SR_CODEC_IDLE: tx_idle     <= iq_word_t'(i_set_data);
            SR_READBACK:   o_rb_sel    <= i_set_data[RB_SEL_W-1:0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Front-end words

   // Idle word goes out whenever transmit is not running
   // Loopback takes the transmit word of the previous cycle
   always_ff @(posedge i_radio_clk) begin
      if (i_radio_rst) begin
         o_tx    <= '0;
         o_rx_fe <= '0;
      end else begin
         o_tx    <= i_run_tx ? i_tx_sample : tx_idle;
         o_rx_fe <= loopback ? o_tx : i_rx;
      end
   end

endmodule

/* radio_readback_mux.sv */
// Combinational selector for the 64-bit readback word the host sees over Wishbone
module radio_readback_mux #(
   parameter int NUM_ATR_BANKS = 2,
   parameter int GPIO_WIDTH    = radio_signal_pkg::GPIO_DEFAULT_W
) (
   input  logic [radio_regs_pkg::RB_SEL_W-1:0]   i_rb_sel,
   input  radio_signal_pkg::vita_time_t          i_vita_time,
   input  radio_signal_pkg::vita_time_t          i_vita_time_pps,
   input  radio_signal_pkg::wb_data_t            i_test_word,
   input  radio_signal_pkg::iq_word_t            i_tx,
   input  radio_signal_pkg::iq_word_t            i_rx,
   input  logic [NUM_ATR_BANKS*GPIO_WIDTH-1:0]   i_gpio_rb,
   output radio_signal_pkg::rb_word_t            o_rb_data
);
   import radio_signal_pkg::*;
   import radio_regs_pkg::*;

   // Bank 0 lands in the low bits, upper bits zero
   always_comb begin
      case (i_rb_sel)
         RB_TEST:     o_rb_data = rb_word_t'(i_test_word);
         RB_TIME:     o_rb_data = i_vita_time;
         RB_TIME_PPS: o_rb_data = i_vita_time_pps;
         // Transmit word high, raw receive input low
         RB_FRONTEND: o_rb_data = {i_tx, i_rx};
         RB_GPIO:     o_rb_data = rb_word_t'(i_gpio_rb);
         default:     o_rb_data = '0;
      endcase
   end

endmodule

/* radio_regs_pkg.sv */
// Settings address map, readback selector codes and ATR offsets shared by the radio core blocks
package radio_regs_pkg;

   ////////////////////////////////////////
   // Settings addresses

   localparam radio_signal_pkg::set_addr_t SR_LOOPBACK   = 8'd6;
   localparam radio_signal_pkg::set_addr_t SR_TEST       = 8'd21;
   localparam radio_signal_pkg::set_addr_t SR_CODEC_IDLE = 8'd22;
   localparam radio_signal_pkg::set_addr_t SR_READBACK   = 8'd32;

   // Time load registers, bit 0 of ctrl selects load on next pulse
   localparam radio_signal_pkg::set_addr_t SR_TIME_HI    = 8'd128;
   localparam radio_signal_pkg::set_addr_t SR_TIME_LO    = 8'd129;
   localparam radio_signal_pkg::set_addr_t SR_TIME_CTRL  = 8'd130;

   // Bank k sits at SR_ATR_BASE + k * SR_ATR_STRIDE
   localparam int SR_ATR_BASE   = 64;
   localparam int SR_ATR_STRIDE = 8;

   // Offsets inside one bank
   localparam int ATR_IDLE = 0;
   localparam int ATR_RX   = 1;
   localparam int ATR_TX   = 2;
   localparam int ATR_FDX  = 3;
   localparam int ATR_DDR  = 4;

   ////////////////////////////////////////
   // Readback select, codes 5 to 7 read zero

   localparam int RB_SEL_W = 3;

   localparam logic [RB_SEL_W-1:0] RB_TEST     = 3'd0;
   localparam logic [RB_SEL_W-1:0] RB_TIME     = 3'd1;
   localparam logic [RB_SEL_W-1:0] RB_TIME_PPS = 3'd2;
   localparam logic [RB_SEL_W-1:0] RB_FRONTEND = 3'd3;
   localparam logic [RB_SEL_W-1:0] RB_GPIO     = 3'd4;

   // Wishbone read addresses for the two readback halves
   localparam radio_signal_pkg::set_addr_t WB_RB_LO = 8'd0;
   localparam radio_signal_pkg::set_addr_t WB_RB_HI = 8'd1;

endpackage

/* radio_signal_pkg.sv */
// Shared widths and data types for front-end samples, time, GPIO and bus words; import where needed
package radio_signal_pkg;

   ////////////////////////////////////////
   // Widths

   // Each I or Q component is 16 bits
   localparam int IQ_HALF_W      = 16;
   localparam int IQ_W           = 2 * IQ_HALF_W;
   localparam int TIME_W         = 64;
   localparam int WB_DATA_W      = 32;
   localparam int SET_ADDR_W     = 8;
   localparam int RB_W           = 64;

   // Pins per ATR bank unless the top level says otherwise
   localparam int GPIO_DEFAULT_W = 16;

   ////////////////////////////////////////
   // Types

   // I in the upper half, Q in the lower half
   typedef logic [IQ_W-1:0]       iq_word_t;

   // Radio clock ticks
   typedef logic [TIME_W-1:0]     vita_time_t;

   typedef logic [WB_DATA_W-1:0]  wb_data_t;

   // Settings address, also the Wishbone word address
   typedef logic [SET_ADDR_W-1:0] set_addr_t;

   typedef logic [RB_W-1:0]       rb_word_t;

endpackage

/* radio_timekeeper.sv */
// Free-running 64-bit radio time with pulse-per-second latch and immediate or pulse-aligned load
module radio_timekeeper (
   input  logic                          i_radio_clk,
   input  logic                          i_radio_rst,
   input  logic                          i_set_stb,
   input  radio_signal_pkg::set_addr_t   i_set_addr,
   input  radio_signal_pkg::wb_data_t    i_set_data,
   input  logic                          i_pps,
   output radio_signal_pkg::vita_time_t  o_vita_time,
   output radio_signal_pkg::vita_time_t  o_vita_time_pps
);
   import radio_signal_pkg::*;
   import radio_regs_pkg::*;

   wb_data_t   time_hi;
   wb_data_t   time_lo;
   logic       load_on_pps;
   logic       load_pending;
   logic       lo_write;
   logic       pps_q;
   logic       pps_q_d;
   logic       pps_edge;
   vita_time_t next_time;

   assign lo_write = i_set_stb && (i_set_addr == SR_TIME_LO);

   // Pulse sampled once, edge found against its previous value
   assign pps_edge = pps_q & ~pps_q_d;

   ////////////////////////////////////////
   // Load registers

   always_ff @(posedge i_radio_clk) begin
      if (i_radio_rst) begin
         time_hi      <= '0;
         time_lo      <= '0;
         load_on_pps  <= 1'b0;
         load_pending <= 1'b0;
      end else begin
         if (i_set_stb) begin
            case (i_set_addr)
               SR_TIME_HI:   time_hi     <= i_set_data;
               SR_TIME_LO:   time_lo     <= i_set_data;
               SR_TIME_CTRL: load_on_pps <= i_set_data[0];
               default: ;
            endcase
         end
         // Writing lo arms the pulse load; a write on the edge waits for the next one
         if (lo_write && load_on_pps)
            load_pending <= 1'b1;
         else if (pps_edge)
            load_pending <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // Counter

   always_comb begin
      if (lo_write && !load_on_pps)
         next_time = {time_hi, i_set_data};
      else if (pps_edge && load_pending)
         next_time = {time_hi, time_lo};
      else
         next_time = o_vita_time + 1'b1;
   end

   // The pulse latch keeps the count taken on the edge, loaded value included
   always_ff @(posedge i_radio_clk) begin
      if (i_radio_rst) begin
         pps_q           <= 1'b0;
         pps_q_d         <= 1'b0;
         o_vita_time     <= '0;
         o_vita_time_pps <= '0;
      end else begin
         pps_q       <= i_pps;
         pps_q_d     <= pps_q;
         o_vita_time <= next_time;
         if (pps_edge)
            o_vita_time_pps <= next_time;
      end
   end

endmodule

/* tb_radio_core.sv */
// Self-checking testbench that drives radio_core_top with LFSR stimulus as the simulation top
module tb_radio_core;
   import radio_signal_pkg::*;
   import radio_regs_pkg::*;

   localparam int NUM_BANKS = 2;
   localparam int GPIO_W    = 16;
   localparam int GPIO_ALL  = NUM_BANKS * GPIO_W;
   // Whole sequence needs under 200 cycles
   localparam int MAX_CYCLES = 4000;

   logic                radio_clk;
   logic                radio_rst;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   set_addr_t           wb_adr;
   wb_data_t            wb_dat_w;
   wb_data_t            wb_dat_r;
   logic                wb_ack;
   iq_word_t            rx;
   iq_word_t            tx;
   iq_word_t            rx_fe;
   iq_word_t            tx_sample;
   logic                run_tx;
   logic                run_rx;
   logic                pps;
   logic [GPIO_ALL-1:0] gpio_in;
   logic [GPIO_ALL-1:0] gpio_out;
   logic [GPIO_ALL-1:0] gpio_ddr;

   logic [15:0]         lfsr_state = 16'd64145;
   int                  cycle_count = 0;
   int                  errors = 0;
   int                  checks = 0;
   logic [GPIO_W-1:0]   atr_model [NUM_BANKS][5];

   radio_core_top #(.NUM_ATR_BANKS(NUM_BANKS), .GPIO_WIDTH(GPIO_W)) UUT (
      .i_radio_clk (radio_clk),  .i_radio_rst (radio_rst),
      .i_wb_cyc    (wb_cyc),     .i_wb_stb    (wb_stb),
      .i_wb_we     (wb_we),      .i_wb_adr    (wb_adr),
      .i_wb_dat    (wb_dat_w),   .o_wb_dat    (wb_dat_r),
      .o_wb_ack    (wb_ack),     .i_rx        (rx),
      .o_tx        (tx),         .o_rx_fe     (rx_fe),
      .i_tx_sample (tx_sample),  .i_run_tx    (run_tx),
      .i_run_rx    (run_rx),     .i_pps       (pps),
      .i_gpio_in   (gpio_in),    .o_gpio_out  (gpio_out),
      .o_gpio_ddr  (gpio_ddr)
   );

   initial begin
      radio_clk = 1'b0;
      forever #5 radio_clk = ~radio_clk;
   end

   always @(posedge radio_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
         $display("Done: errors found");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers

   // Taps from x^16 + x^14 + x^13 + x^11 + 1
   // New bits enter at the LSB
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         val = {val[30:0], fb};
      end
      return val;
   endfunction

   // ATR register offset picked by the run flags
   function automatic int atr_offset(input logic tx_on, input logic rx_on);
      int off;
      case ({tx_on, rx_on})
         2'b01:   off = ATR_RX;
         2'b10:   off = ATR_TX;
         2'b11:   off = ATR_FDX;
         default: off = ATR_IDLE;
      endcase
      return off;
   endfunction

   task automatic tick();
      @(posedge radio_clk);
      #1;
   endtask

   task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_range(input string what, input logic [63:0] got,
                              input logic [63:0] base, input logic [63:0] span);
      checks++;
      if (got < base || got > base + span) begin
         errors++;
         $display("ERROR at %0t: %s is %h, outside %h plus %0d", $time, what, got, base, span);
      end
   endtask

   // Request held until the acknowledge shows up
   task automatic wb_write(input set_addr_t adr, input wb_data_t dat);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = dat;
      tick();
      while (!wb_ack)
         tick();
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_read(input set_addr_t adr, output wb_data_t dat);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      tick();
      while (!wb_ack)
         tick();
      dat    = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   // Low half first so it captures the high half
   task automatic read_rb64(output logic [63:0] val);
      wb_data_t lo;
      wb_data_t hi;
      wb_read(WB_RB_LO, lo);
      wb_read(WB_RB_HI, hi);
      val = {hi, lo};
   endtask

   ////////////////////////////////////////
   // Test sequence

   initial begin
      wb_data_t            word;
      wb_data_t            rd_lo;
      wb_data_t            rd_hi;
      wb_data_t            rnd;
      logic [63:0]         rd64;
      logic [63:0]         load_val;
      logic [63:0]         pps_val;
      logic [63:0]         gpio_exp;
      int                  load_cycle;
      int                  pulse_cycle;
      iq_word_t            idle_model;
      iq_word_t            model_tx;
      iq_word_t            exp_rx_fe;
      logic [1:0]          state;
      logic [GPIO_ALL-1:0] exp_out;
      logic [GPIO_ALL-1:0] exp_ddr;

      radio_rst = 1'b1;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      rx        = '0;
      tx_sample = '0;
      run_tx    = 1'b0;
      run_rx    = 1'b0;
      pps       = 1'b0;
      gpio_in   = '0;
      repeat (4) @(posedge radio_clk);
      #1;
      radio_rst = 1'b0;

      // Reset values
      check_eq("ddr after reset", 64'(gpio_ddr), 64'({GPIO_ALL{1'b1}}));
      check_eq("tx after reset", 64'(tx), 64'd0);
      check_eq("gpio out after reset", 64'(gpio_out), 64'd0);
      check_eq("ack after reset", 64'(wb_ack), 64'd0);

      // Test word readback
      wb_write(SR_READBACK, wb_data_t'(RB_TEST));
      for (int i = 0; i < 8; i++) begin
         word = rand_bits(32);
         wb_write(SR_TEST, word);
         wb_read(WB_RB_LO, rd_lo);
         check_eq("test word low", 64'(rd_lo), 64'(word));
         wb_read(WB_RB_HI, rd_hi);
         check_eq("test word high", 64'(rd_hi), 64'd0);
      end

      // Immediate time load
      wb_write(SR_READBACK, wb_data_t'(RB_TIME));
      load_val = {rand_bits(32), rand_bits(32)};
      wb_write(SR_TIME_HI, load_val[63:32]);
      wb_write(SR_TIME_LO, load_val[31:0]);
      load_cycle = cycle_count;
      read_rb64(rd64);
      check_range("time after load", rd64, load_val, 64'(cycle_count - load_cycle));

      // Pulse-aligned load stays pending until the pulse
      pps_val = {rand_bits(32), rand_bits(32)};
      wb_write(SR_TIME_CTRL, 32'd1);
      wb_write(SR_TIME_HI, pps_val[63:32]);
      wb_write(SR_TIME_LO, pps_val[31:0]);
      repeat (5) tick();
      read_rb64(rd64);
      check_range("time before pulse", rd64, load_val, 64'(cycle_count - load_cycle));
      pps = 1'b1;
      pulse_cycle = cycle_count;
      // One register stage plus the load cycle
      repeat (3) tick();
      pps = 1'b0;
      wb_write(SR_READBACK, wb_data_t'(RB_TIME_PPS));
      read_rb64(rd64);
      check_range("pulse latch", rd64, pps_val, 64'(cycle_count - pulse_cycle));
      wb_write(SR_READBACK, wb_data_t'(RB_TIME));
      read_rb64(rd64);
      check_range("time after pulse", rd64, pps_val, 64'(cycle_count - pulse_cycle));

      // Transmit rule and loopback
      idle_model = rand_bits(32);
      wb_write(SR_CODEC_IDLE, idle_model);
      for (int lb = 0; lb < 2; lb++) begin
         wb_write(SR_LOOPBACK, wb_data_t'(lb));
         repeat (2) tick();
         model_tx = run_tx ? tx_sample : idle_model;
         for (int i = 0; i < 16; i++) begin
            tx_sample = rand_bits(32);
            rnd       = rand_bits(1);
            run_tx    = rnd[0];
            rx        = rand_bits(32);
            exp_rx_fe = (lb == 1) ? model_tx : rx;
            model_tx  = run_tx ? tx_sample : idle_model;
            tick();
            check_eq("tx word", 64'(tx), 64'(model_tx));
            check_eq("rx front-end word", 64'(rx_fe), 64'(exp_rx_fe));
         end
      end
      wb_write(SR_READBACK, wb_data_t'(RB_FRONTEND));
      wb_read(WB_RB_LO, rd_lo);
      check_eq("front-end readback low", 64'(rd_lo), 64'(rx));
      wb_read(WB_RB_HI, rd_hi);
      check_eq("front-end readback high", 64'(rd_hi), 64'(model_tx));

      // ATR banks
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int r = 0; r < 5; r++) begin
            word = rand_bits(32);
            atr_model[b][r] = word[GPIO_W-1:0];
            wb_write(set_addr_t'(SR_ATR_BASE + b * SR_ATR_STRIDE + r), word);
         end
      end
      // Last direction write reaches the pins one cycle after the register
      tick();
      for (int combo = 0; combo < 4; combo++) begin
         state  = combo[1:0];
         run_tx = state[1];
         run_rx = state[0];
         tick();
         for (int b = 0; b < NUM_BANKS; b++) begin
            exp_out[b*GPIO_W +: GPIO_W] = atr_model[b][atr_offset(run_tx, run_rx)];
            exp_ddr[b*GPIO_W +: GPIO_W] = atr_model[b][ATR_DDR];
         end
         check_eq("gpio out", 64'(gpio_out), 64'(exp_out));
         check_eq("gpio ddr", 64'(gpio_ddr), 64'(exp_ddr));
      end
      gpio_in = rand_bits(GPIO_ALL);
      gpio_exp = 64'(gpio_in);
      tick();
      wb_write(SR_READBACK, wb_data_t'(RB_GPIO));
      wb_read(WB_RB_LO, rd_lo);
      check_eq("gpio readback low", 64'(rd_lo), 64'(gpio_exp[31:0]));
      wb_read(WB_RB_HI, rd_hi);
      check_eq("gpio readback high", 64'(rd_hi), 64'(gpio_exp[63:32]));

      errors = errors + int'(UUT.u_wb_slave.u_wb_assert.fail_count);
      $display("Checks: %0d, errors: %0d (assertion failures: %0d)", checks, errors,
               UUT.u_wb_slave.u_wb_assert.fail_count);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* wb_settings_slave.sv */
// Wishbone classic slave: host writes become settings strobes, host reads return readback halves
module wb_settings_slave (
   input  logic                          i_radio_clk,
   input  logic                          i_radio_rst,
   // Wishbone classic, host is master
   input  logic                          i_wb_cyc,
   input  logic                          i_wb_stb,
   input  logic                          i_wb_we,
   input  radio_signal_pkg::set_addr_t   i_wb_adr,
   input  radio_signal_pkg::wb_data_t    i_wb_dat,
   output radio_signal_pkg::wb_data_t    o_wb_dat,
   output logic                          o_wb_ack,
   // Settings bus
   output logic                          o_set_stb,
   output radio_signal_pkg::set_addr_t   o_set_addr,
   output radio_signal_pkg::wb_data_t    o_set_data,
   // Selected readback word
   input  radio_signal_pkg::rb_word_t    i_rb_data
);
   import radio_signal_pkg::*;
   import radio_regs_pkg::*;

   logic     wb_req;
   wb_data_t rb_hi;

   // New request only while no acknowledge is out, so ack never lasts two cycles
   assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;

   ////////////////////////////////////////
   // Handshake and write strobe

   always_ff @(posedge i_radio_clk) begin
      if (i_radio_rst) begin
         o_wb_ack  <= 1'b0;
         o_set_stb <= 1'b0;
      end else begin
         o_wb_ack  <= wb_req;
         o_set_stb <= wb_req & i_wb_we;
      end
   end

   always_ff @(posedge i_radio_clk) begin
      if (wb_req) begin
         o_set_addr <= i_wb_adr;
         o_set_data <= i_wb_dat;
      end
   end

   ////////////////////////////////////////
   // Readback

   // Low read grabs both halves at once so a 64-bit time value stays coherent
   always_ff @(posedge i_radio_clk) begin
      if (wb_req && !i_wb_we) begin
         case (i_wb_adr)
            WB_RB_LO: begin
               o_wb_dat <= i_rb_data[WB_DATA_W-1:0];
               rb_hi    <= i_rb_data[RB_W-1:WB_DATA_W];
            end
            WB_RB_HI: begin
               o_wb_dat <= rb_hi;
            end
            default: begin
               o_wb_dat <= '0;
            end
         endcase
      end
   end

endmodule
